// File: filelist.f
verilog/fetch_pkg.sv
verilog/branch_predictor.sv
verilog/fetch_unit.sv
verilog/prog_loader.sv
verilog/imem_arbiter.sv
verilog/imem.sv
verilog/fetch_top.sv
tests/fetch_chk.sv
tests/fetch_tb.sv

// File: tests/fetch_chk.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_chk (
    input wire logic CLK,
    input wire logic rst,
    input wire logic loader_grant,
    input wire logic fetch_grant,
    input wire logic redirect_valid,
    input wire logic fetch_valid,
    input wire logic bvalid,
    input wire logic bready
);

    // the loader and the fetch unit share one memory port.
    one_grant: assert property (@(posedge CLK) disable iff (rst)
        !(loader_grant && fetch_grant)) else $error("both memory grants are high together");

    redirect_drop: assert property (@(posedge CLK) disable iff (rst)
        redirect_valid |-> !fetch_valid) else $error("instruction delivered during a redirect");

    bvalid_hold: assert property (@(posedge CLK) disable iff (rst)
        bvalid && !bready |=> bvalid) else $error("bvalid dropped before bready");

endmodule

bind fetch_top fetch_chk fetch_chk_inst (
    .CLK(CLK), .rst(rst),
    .loader_grant(loader_grant), .fetch_grant(fetch_grant),
    .redirect_valid(redirect_valid), .fetch_valid(fetch_valid),
    .bvalid(bvalid), .bready(bready)
);

`default_nettype wire

// File: tests/fetch_tb.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_tb
    import fetch_pkg::*;
();

    localparam int N_LOAD  = 1024;
    localparam int N_CHECK = 40;
    localparam int N_LIVE  = 40;
    localparam int N_FETCH = 3000;
    localparam int LIMIT   = 40 * (N_LOAD + 2 * N_CHECK + N_LIVE + N_FETCH);

    logic CLK, rst, run;
    logic [31:0] awaddr, araddr;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    instr_t wdata, rdata, fetch_instr;
    logic [3:0] wstrb;
    logic [1:0] bresp, rresp;
    logic fetch_valid, fetch_pred_taken;
    logic resolve_valid, resolve_taken, redirect_valid;
    pc_t fetch_pc, resolve_pc, redirect_pc;

    instr_t mem_mirror [1024];
    ctr_t ctr_mirror [64];
    int errs [3]; // axi, fetch stream and prediction errors.
    int fetch_count = 0;
    int cycles = 0;
    logic [31:0] rng = 32'h0a87_b53e;

    fetch_top fetch_top_inst (.*);

    function logic [31:0] rand_next();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // words below index 32 never redirect, so fetch starts on a straight line.
    function automatic instr_t make_instr(input logic [31:0] r, input logic mixed);
        if (mixed && r[1:0] == 2'd0) return {r[31:7], OPC_JAL};
        if (mixed && r[1]) return {r[31:7], OPC_BRANCH};
        return {r[31:7], 7'b0010011};
    endfunction

    function automatic pc_t target_of(input instr_t ins, input pc_t pc);
        logic [31:0] imm;
        if (ins[6:0] == OPC_JAL) begin
            imm = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        end else begin
            imm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        end
        return pc + imm[11:0];
    endfunction

    task automatic check_eq(input string name, input int kind, input logic [31:0] expected,
                            input logic [31:0] actual);
        assert (expected === actual) else begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            errs[kind]++;
        end
    endtask

    task automatic print_counts();
        $display("errors: axi %0d, fetch %0d, prediction %0d", errs[0], errs[1], errs[2]);
    endtask

    task automatic axi_write(input logic [31:0] addr, input instr_t data);
        logic hs;
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'(rand_next());
        awvalid = 1'b1;
        wvalid  = 1'b1;
        hs = 1'b0;
        while (!hs) begin
            #5 hs = awready && wready;
            @(posedge CLK);
            #1;
        end
        {awvalid, wvalid} = 2'b00;
        repeat (rand_next() % 4) begin
            @(posedge CLK);
            #1;
        end
        bready = 1'b1;
        #5;
        check_eq("bvalid", 0, 32'd1, bvalid);
        check_eq("bresp", 0, RESP_OKAY, bresp);
        @(posedge CLK);
        #1 bready = 1'b0;
    endtask

    task automatic axi_read(input logic [31:0] addr);
        logic hs;
        instr_t expected;
        araddr  = addr;
        arvalid = 1'b1;
        hs = 1'b0;
        while (!hs) begin
            #5 hs = arready;
            @(posedge CLK);
            #1;
        end
        arvalid  = 1'b0;
        expected = mem_mirror[addr[11:2]];
        repeat (rand_next() % 4) begin
            @(posedge CLK);
            #1;
        end
        rready = 1'b1;
        #5;
        check_eq("rvalid", 0, 32'd1, rvalid);
        check_eq("rresp", 0, RESP_OKAY, rresp);
        check_eq("readback", 0, expected, rdata);
        @(posedge CLK);
        #1 rready = 1'b0;
    endtask

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    initial begin
        while (cycles < LIMIT) begin
            @(posedge CLK);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", LIMIT);
        print_counts();
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        logic [31:0] r;
        pc_t wpc;
        {awvalid, wvalid, bready, arvalid, rready, run} = '0;
        {resolve_valid, resolve_taken, redirect_valid} = '0;
        {awaddr, araddr, wdata, wstrb} = '0;
        resolve_pc  = '0;
        redirect_pc = '0;
        rst = 1'b1;
        repeat (5) @(posedge CLK);
        #1 rst = 1'b0;
        for (int i = 0; i < N_LOAD; i++) begin
            r = rand_next();
            axi_write({r[19:0], 10'(i), 2'b00}, make_instr(rand_next(), i >= 32));
        end
        for (int i = 0; i < N_CHECK; i++) begin
            r = rand_next();
            axi_write({r[31:2], 2'b00}, make_instr(rand_next(), r[11:2] >= 10'd32));
            axi_read(rand_next());
        end
        run = 1'b1;
        for (int i = 0; i < N_LIVE; i++) begin
            repeat (rand_next() % 16) begin
                @(posedge CLK);
                #1;
            end
            r   = rand_next();
            wpc = fetch_pc + 12'd8; // a word that is likely to be fetched soon.
            axi_write({r[19:0], wpc[11:2], 2'b00}, make_instr(rand_next(), wpc[11:2] >= 10'd32));
        end
        wait (fetch_count >= N_FETCH);
        print_counts();
        if (errs[0] + errs[1] + errs[2] == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // the execute stage stand-in resolves each branch one cycle after it is fetched.
    initial begin
        instr_t ins;
        logic pred, taken, do_redirect, do_resolve, res_taken;
        pc_t redirect_to, res_pc, exp_pc;
        logic [5:0] idx;
        for (int i = 0; i < 64; i++) ctr_mirror[i] = CTR_RESET;
        {do_redirect, do_resolve, res_taken} = '0;
        {redirect_to, res_pc, exp_pc} = '0;
        forever begin
            @(posedge CLK);
            #1;
            redirect_valid = do_redirect;
            redirect_pc    = redirect_to;
            resolve_valid  = do_resolve;
            resolve_pc     = res_pc;
            resolve_taken  = res_taken;
            {do_redirect, do_resolve} = 2'b00;
            #5;
            if (!rst) begin
                if (redirect_valid) begin
                    assert (!fetch_valid) else begin
                        $display("error: an instruction came out in the cycle of a redirect");
                        errs[1]++;
                    end
                end
                if (fetch_valid) begin
                    ins  = mem_mirror[fetch_pc[11:2]];
                    pred = (ins[6:0] == OPC_JAL) || (ins[6:0] == OPC_BRANCH &&
                           ctr_mirror[fetch_pc[7:2]] >= CTR_TAKEN_MIN);
                    check_eq("fetch_pc", 1, exp_pc, fetch_pc);
                    check_eq("fetch_instr", 1, ins, fetch_instr);
                    check_eq("fetch_pred_taken", 2, pred, fetch_pred_taken);
                    taken = pred;
                    if (ins[6:0] == OPC_BRANCH) begin
                        taken      = 1'(rand_next());
                        do_resolve = 1'b1;
                        res_pc     = fetch_pc;
                        res_taken  = taken;
                    end
                    exp_pc      = taken ? target_of(ins, fetch_pc) : fetch_pc + 12'd4;
                    do_redirect = (taken != pred); // mispredicted, so steer to the right path.
                    redirect_to = exp_pc;
                    fetch_count++;
                end
                if (resolve_valid) begin
                    idx = resolve_pc[7:2];
                    if (resolve_taken && ctr_mirror[idx] != 2'd3) ctr_mirror[idx]++;
                    else if (!resolve_taken && ctr_mirror[idx] != 2'd0) ctr_mirror[idx]--;
                end
                if (awvalid && awready) mem_mirror[awaddr[11:2]] = wdata;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/branch_predictor.sv
`timescale 1ns/1ns
`default_nettype none

module branch_predictor
    import fetch_pkg::*;
(
    input  wire logic   CLK,
    input  wire logic   rst,
    input  wire pc_t    lookup_pc,
    input  wire instr_t lookup_instr,
    input  wire logic   resolve_valid,
    input  wire pc_t    resolve_pc,
    input  wire logic   resolve_taken,
    output logic        pred_taken,
    output pc_t         pred_target
);

    ctr_t bht [BHT_ENTRIES];

    logic [BHT_INDEX_BITS-1:0] lookup_idx;
    logic [BHT_INDEX_BITS-1:0] resolve_idx;
    logic [6:0] opcode;
    ctr_t lookup_ctr;
    ctr_t resolve_ctr;
    pc_t j_offset;
    pc_t b_offset;

    assign lookup_idx  = lookup_pc[BHT_INDEX_BITS+1:2];
    assign resolve_idx = resolve_pc[BHT_INDEX_BITS+1:2];
    assign opcode      = lookup_instr[6:0];
    assign lookup_ctr  = bht[lookup_idx];
    assign resolve_ctr = bht[resolve_idx];

    // only the low 12 immediate bits matter since the pc wraps at 12 bits.
    assign j_offset = {lookup_instr[20], lookup_instr[30:21], 1'b0};
    assign b_offset = {lookup_instr[7], lookup_instr[30:25], lookup_instr[11:8], 1'b0};

    always_comb begin
        pred_taken  = 1'b0;
        pred_target = lookup_pc + b_offset;
        if (opcode == OPC_JAL) begin
            pred_taken  = 1'b1; // jumps are always taken.
            pred_target = lookup_pc + j_offset;
        end else if (opcode == OPC_BRANCH) begin
            pred_taken = (lookup_ctr >= CTR_TAKEN_MIN);
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            for (int i = 0; i < BHT_ENTRIES; i++) begin
                bht[i] <= CTR_RESET;
            end
        end else if (resolve_valid) begin
            if (resolve_taken && resolve_ctr != 2'd3) begin
                bht[resolve_idx] <= resolve_ctr + 2'd1;
            end else if (!resolve_taken && resolve_ctr != 2'd0) begin
                bht[resolve_idx] <= resolve_ctr - 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    typedef logic [11:0] pc_t;        // byte address into instruction memory.
    typedef logic [31:0] instr_t;
    typedef logic [9:0]  imem_addr_t; // word index, pc bits 11..2.
    typedef logic [1:0]  ctr_t;

    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    localparam int BHT_INDEX_BITS = 6;
    localparam int BHT_ENTRIES    = 64;

    // a fresh counter is weakly not taken.
    localparam ctr_t CTR_RESET     = 2'd1;
    localparam ctr_t CTR_TAKEN_MIN = 2'd2;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    typedef enum logic [2:0] {
        LD_IDLE,
        LD_WR_GRANT,
        LD_WR_RESP,
        LD_RD_GRANT,
        LD_RD_DATA
    } loader_state_t;

endpackage

`default_nettype wire

// File: verilog/fetch_top.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_top
    import fetch_pkg::*;
(
    input  wire logic        CLK,
    input  wire logic        rst,
    input  wire logic [31:0] awaddr,
    input  wire logic        awvalid,
    output logic             awready,
    input  wire instr_t      wdata,
    input  wire logic [3:0]  wstrb,
    input  wire logic        wvalid,
    output logic             wready,
    output logic [1:0]       bresp,
    output logic             bvalid,
    input  wire logic        bready,
    input  wire logic [31:0] araddr,
    input  wire logic        arvalid,
    output logic             arready,
    output instr_t           rdata,
    output logic [1:0]       rresp,
    output logic             rvalid,
    input  wire logic        rready,
    input  wire logic        run,
    output logic             fetch_valid,
    output pc_t              fetch_pc,
    output instr_t           fetch_instr,
    output logic             fetch_pred_taken,
    input  wire logic        resolve_valid,
    input  wire pc_t         resolve_pc,
    input  wire logic        resolve_taken,
    input  wire logic        redirect_valid,
    input  wire pc_t         redirect_pc
);

    logic       loader_req, loader_we, loader_grant;
    imem_addr_t loader_addr;
    instr_t     loader_wdata;
    logic       fetch_req, fetch_grant;
    imem_addr_t fetch_addr;
    logic       mem_en, mem_we;
    imem_addr_t mem_addr;
    instr_t     mem_wdata, mem_rdata;
    pc_t        lookup_pc, pred_target;
    instr_t     lookup_instr;
    logic       pred_taken;

    prog_loader prog_loader_inst (
        .CLK(CLK), .rst(rst),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .req(loader_req), .req_we(loader_we), .req_addr(loader_addr),
        .req_wdata(loader_wdata), .grant(loader_grant), .mem_rdata(mem_rdata)
    );

    fetch_unit fetch_unit_inst (
        .CLK(CLK), .rst(rst), .run(run),
        .req(fetch_req), .req_addr(fetch_addr), .grant(fetch_grant), .rdata(mem_rdata),
        .lookup_pc(lookup_pc), .lookup_instr(lookup_instr),
        .pred_taken(pred_taken), .pred_target(pred_target),
        .redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
        .fetch_valid(fetch_valid), .fetch_pc(fetch_pc),
        .fetch_instr(fetch_instr), .fetch_pred_taken(fetch_pred_taken)
    );

    branch_predictor branch_predictor_inst (
        .CLK(CLK), .rst(rst),
        .lookup_pc(lookup_pc), .lookup_instr(lookup_instr),
        .resolve_valid(resolve_valid), .resolve_pc(resolve_pc),
        .resolve_taken(resolve_taken),
        .pred_taken(pred_taken), .pred_target(pred_target)
    );

    imem_arbiter imem_arbiter_inst (
        .loader_req(loader_req), .loader_we(loader_we), .loader_addr(loader_addr),
        .loader_wdata(loader_wdata), .loader_grant(loader_grant),
        .fetch_req(fetch_req), .fetch_addr(fetch_addr), .fetch_grant(fetch_grant),
        .mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata)
    );

    imem imem_inst (
        .CLK(CLK), .en(mem_en), .we(mem_we), .addr(mem_addr),
        .wdata(mem_wdata), .rdata(mem_rdata)
    );

endmodule

`default_nettype wire

// File: verilog/fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_unit
    import fetch_pkg::*;
(
    input  wire logic   CLK,
    input  wire logic   rst,
    input  wire logic   run,
    output logic        req,
    output imem_addr_t  req_addr,
    input  wire logic   grant,
    input  wire instr_t rdata,
    output pc_t         lookup_pc,
    output instr_t      lookup_instr,
    input  wire logic   pred_taken,
    input  wire pc_t    pred_target,
    input  wire logic   redirect_valid,
    input  wire pc_t    redirect_pc,
    output logic        fetch_valid,
    output pc_t         fetch_pc,
    output instr_t      fetch_instr,
    output logic        fetch_pred_taken
);

    // pc is the address of the word in flight while pending is set,
    // otherwise the address still waiting for a grant.
    pc_t  pc;
    logic pending;
    pc_t  next_pc;

    always_comb begin
        if (redirect_valid) begin
            next_pc = redirect_pc;
        end else if (pending) begin
            next_pc = pred_taken ? pred_target : pc + pc_t'(4);
        end else begin
            next_pc = pc;
        end
    end

    assign req      = run;
    assign req_addr = next_pc[11:2];

    // the returning word goes straight to the predictor.
    assign lookup_pc    = pc;
    assign lookup_instr = rdata;

    assign fetch_valid      = pending && !redirect_valid; // a redirect drops the stale word.
    assign fetch_pc         = pc;
    assign fetch_instr      = rdata;
    assign fetch_pred_taken = pred_taken;

    always_ff @(posedge CLK) begin
        if (rst) begin
            pc      <= '0;
            pending <= 1'b0;
        end else begin
            pc      <= next_pc;
            pending <= req && grant;
        end
    end

endmodule

`default_nettype wire

// File: verilog/imem.sv
`timescale 1ns/1ns
`default_nettype none

module imem
    import fetch_pkg::*;
(
    input  wire logic       CLK,
    input  wire logic       en,
    input  wire logic       we,
    input  wire imem_addr_t addr,
    input  wire instr_t     wdata,
    output instr_t          rdata
);

    instr_t mem [2**$bits(imem_addr_t)];

    // rdata only changes on an enabled read.
    always_ff @(posedge CLK) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/imem_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module imem_arbiter
    import fetch_pkg::*;
(
    input  wire logic       loader_req,
    input  wire logic       loader_we,
    input  wire imem_addr_t loader_addr,
    input  wire instr_t     loader_wdata,
    output logic            loader_grant,
    input  wire logic       fetch_req,
    input  wire imem_addr_t fetch_addr,
    output logic            fetch_grant,
    output logic            mem_en,
    output logic            mem_we,
    output imem_addr_t      mem_addr,
    output instr_t          mem_wdata
);

    // fixed priority, the loader always wins.
    assign loader_grant = loader_req;
    assign fetch_grant  = fetch_req && !loader_req;

    assign mem_en    = loader_req || fetch_req;
    assign mem_we    = loader_req && loader_we; // fetch only ever reads.
    assign mem_addr  = loader_req ? loader_addr : fetch_addr;
    assign mem_wdata = loader_wdata;

endmodule

`default_nettype wire

// File: verilog/prog_loader.sv
`timescale 1ns/1ns
`default_nettype none

module prog_loader
    import fetch_pkg::*;
(
    input  wire logic        CLK,
    input  wire logic        rst,
    input  wire logic [31:0] awaddr,
    input  wire logic        awvalid,
    output logic             awready,
    input  wire instr_t      wdata,
    input  wire logic [3:0]  wstrb,
    input  wire logic        wvalid,
    output logic             wready,
    output logic [1:0]       bresp,
    output logic             bvalid,
    input  wire logic        bready,
    input  wire logic [31:0] araddr,
    input  wire logic        arvalid,
    output logic             arready,
    output instr_t           rdata,
    output logic [1:0]       rresp,
    output logic             rvalid,
    input  wire logic        rready,
    output logic             req,
    output logic             req_we,
    output imem_addr_t       req_addr,
    output instr_t           req_wdata,
    input  wire logic        grant,
    input  wire instr_t      mem_rdata
);

    loader_state_t state;
    logic   rd_fresh;  // memory output holds the read word this cycle.
    instr_t rdata_hold;

    // writes are always whole words, so wstrb plays no part.
    assign req       = (state == LD_WR_GRANT) || (state == LD_RD_GRANT);
    assign req_we    = (state == LD_WR_GRANT);
    assign req_addr  = req_we ? awaddr[11:2] : araddr[11:2];
    assign req_wdata = wdata;

    assign awready = (state == LD_WR_GRANT) && grant;
    assign wready  = awready;
    assign arready = (state == LD_RD_GRANT) && grant;

    assign bvalid = (state == LD_WR_RESP);
    assign bresp  = RESP_OKAY;
    assign rvalid = (state == LD_RD_DATA);
    assign rresp  = RESP_OKAY;
    assign rdata  = rd_fresh ? mem_rdata : rdata_hold;

    always_ff @(posedge CLK) begin
        if (rst) begin
            state    <= LD_IDLE;
            rd_fresh <= 1'b0;
        end else begin
            rd_fresh <= arready;
            case (state)
                LD_IDLE: begin
                    if (awvalid && wvalid) state <= LD_WR_GRANT;
                    else if (arvalid) state <= LD_RD_GRANT;
                end
                LD_WR_GRANT: if (grant) state <= LD_WR_RESP;
                LD_WR_RESP:  if (bready) state <= LD_IDLE;
                LD_RD_GRANT: if (grant) state <= LD_RD_DATA;
                LD_RD_DATA:  if (rready) state <= LD_IDLE;
                default: state <= LD_IDLE;
            endcase
        end
    end

    // keeps the word while the master stalls rready.
    always_ff @(posedge CLK) begin
        if (rd_fresh) rdata_hold <= mem_rdata;
    end

endmodule

`default_nettype wire
